//--- Bender.yml
package:
  name: cache_subsystem

sources:
  - include_dirs:
      - .
    files:
      - cachePkg.sv
      - dataMemory.sv
      - dataCache.sv
      - apbSlavePort.sv
      - cacheSubsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cacheSubsystem.sv

//--- apbSlavePort.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module apbSlavePort (
  input  logic               clock,
  input  logic               reset,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  cachePkg::byteAddrT paddr,
  input  cachePkg::wordT     pwdata,
  input  logic               respValid,
  input  cachePkg::wordT     respData,
  input  cachePkg::countT    hitCount,
  input  cachePkg::countT    missCount,
  output cachePkg::wordT     prdata,
  output logic               pready,
  output logic               pslverr,
  output logic               reqRead,
  output logic               reqWrite,
  output cachePkg::memAddrT  reqAddr,
  output cachePkg::wordT     reqWdata
);
  import cachePkg::*;

  apbStateT state;
  apbStateT nextState;

  logic isMem;
  logic isHitReg;
  logic isMissReg;
  logic isError;
  logic inAccess;

  // =====================================================================
  // Address decode
  // =====================================================================
  assign isMem     = ~paddr[`ADDR_WIDTH-1];   // Lower 4 KB is memory
  assign isHitReg  = (paddr == `HIT_COUNT_ADDR);
  assign isMissReg = (paddr == `MISS_COUNT_ADDR);

  // Unmapped address, or a write to one of the counters
  assign isError = !isMem && (pwrite || !(isHitReg || isMissReg));

  assign inAccess = (state == stAccess) || (state == stWait);

  // =====================================================================
  // Cache request, one pulse in the first access cycle
  // =====================================================================
  assign reqRead  = (state == stAccess) && isMem && !pwrite;
  assign reqWrite = (state == stAccess) && isMem && pwrite;
  assign reqAddr  = paddr[11:2];   // Drop byte offset
  assign reqWdata = pwdata;

  // Memory transfers wait for the cache, everything else is immediate
  assign pready  = inAccess && (isMem ? respValid : 1'b1);
  assign pslverr = inAccess && isError;

  always_comb begin
    prdata = '0;
    if (isMem && !pwrite) begin
      prdata = respData;
    end else if (!pwrite && isHitReg) begin
      prdata = hitCount;
    end else if (!pwrite && isMissReg) begin
      prdata = missCount;
    end
  end

  // =====================================================================
  // Transfer FSM
  // =====================================================================
  always_comb begin
    nextState = state;
    case (state)
      stIdle: begin
        if (psel && !penable) nextState = stAccess;   // Setup cycle seen
      end
      stAccess: begin
        if (isMem && !respValid) nextState = stWait;  // Read miss
        else nextState = stIdle;
      end
      stWait: begin
        if (respValid) nextState = stIdle;
      end
      default: nextState = stIdle;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= stIdle;
    end else begin
      state <= nextState;
    end
  end

  // APB master never raises penable outside a selected transfer
  assert property (@(posedge clock) disable iff (reset) penable |-> psel);

  // A miss is answered by the cache after exactly one wait state
  assert property (@(posedge clock) disable iff (reset)
    (state == stWait) |-> respValid);

endmodule

//--- cachePkg.sv
`include "cache_params.svh"

package cachePkg;

  // Data word as seen on APB and in memory
  typedef logic [`DATA_WIDTH-1:0] wordT;

  // Byte address on the APB side
  typedef logic [`ADDR_WIDTH-1:0] byteAddrT;

  // Word index into memory, byte address bits 11 to 2
  typedef logic [$clog2(`MEM_WORDS)-1:0] memAddrT;

  // Cache line index and tag split of memAddrT
  typedef logic [$clog2(`CACHE_LINES)-1:0] indexT;
  typedef logic [$clog2(`MEM_WORDS)-$clog2(`CACHE_LINES)-1:0] tagT;

  // Performance counters, read back over prdata
  typedef logic [`DATA_WIDTH-1:0] countT;

  // APB slave phases
  typedef enum logic [1:0] {
    stIdle,     // Waiting for a setup cycle
    stAccess,   // First access cycle
    stWait      // Wait state for a read miss
  } apbStateT;

endpackage

//--- cacheSubsystem.sv
`timescale 1ns/1ps

module cacheSubsystem (
  input  logic               clock,
  input  logic               reset,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  cachePkg::byteAddrT paddr,
  input  cachePkg::wordT     pwdata,
  output cachePkg::wordT     prdata,
  output logic               pready,
  output logic               pslverr
);
  import cachePkg::*;

  // Port to cache
  logic    reqRead;
  logic    reqWrite;
  memAddrT reqAddr;
  wordT    reqWdata;
  logic    respValid;
  wordT    respData;
  countT   hitCount;
  countT   missCount;

  // Cache to memory
  logic    memRead;
  logic    memWrite;
  memAddrT memAddr;
  wordT    memWdata;
  wordT    memRdata;

  // =====================================================================
  // APB front end
  // =====================================================================
  apbSlavePort u_apbSlavePort (
    .clock     (clock),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .respValid (respValid),
    .respData  (respData),
    .hitCount  (hitCount),
    .missCount (missCount),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .reqRead   (reqRead),
    .reqWrite  (reqWrite),
    .reqAddr   (reqAddr),
    .reqWdata  (reqWdata)
  );

  dataCache u_dataCache (
    .clock     (clock),
    .reset     (reset),
    .reqRead   (reqRead),
    .reqWrite  (reqWrite),
    .reqAddr   (reqAddr),
    .reqWdata  (reqWdata),
    .memRdata  (memRdata),
    .respValid (respValid),
    .respData  (respData),
    .hitCount  (hitCount),
    .missCount (missCount),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .memAddr   (memAddr),
    .memWdata  (memWdata)
  );

  // Backing store, contents survive reset
  dataMemory u_dataMemory (
    .clock    (clock),
    .memRead  (memRead),
    .memWrite (memWrite),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memRdata (memRdata)
  );

endmodule

//--- cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Data path widths
`define DATA_WIDTH 32
`define ADDR_WIDTH 13   // APB byte address

// Storage sizes
`define MEM_WORDS   1024
`define CACHE_LINES 4

// =====================================================================
// Address map
// =====================================================================
// 0x0000 to 0x0FFF is memory, word aligned by dropping the low two bits
`define HIT_COUNT_ADDR  13'h1000   // Read-hit counter, read only
`define MISS_COUNT_ADDR 13'h1004   // Read-miss counter, read only

`endif

//--- dataCache.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module dataCache (
  input  logic              clock,
  input  logic              reset,
  input  logic              reqRead,
  input  logic              reqWrite,
  input  cachePkg::memAddrT reqAddr,
  input  cachePkg::wordT    reqWdata,
  input  cachePkg::wordT    memRdata,
  output logic              respValid,
  output cachePkg::wordT    respData,
  output cachePkg::countT   hitCount,
  output cachePkg::countT   missCount,
  output logic              memRead,
  output logic              memWrite,
  output cachePkg::memAddrT memAddr,
  output cachePkg::wordT    memWdata
);
  import cachePkg::*;

  // Line storage
  tagT                     tagArray  [`CACHE_LINES];
  wordT                    dataArray [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] validBits;

  indexT reqIndex;
  tagT   reqTag;
  logic  hit;
  logic  readHit;
  logic  readMiss;

  // Outstanding miss, filled one cycle after the request
  logic  missPending;
  indexT missIndex;
  tagT   missTag;

  // =====================================================================
  // Lookup
  // =====================================================================
  assign reqIndex = reqAddr[$bits(indexT)-1:0];
  assign reqTag   = reqAddr[$bits(memAddrT)-1:$bits(indexT)];

  assign hit      = validBits[reqIndex] && (tagArray[reqIndex] == reqTag);
  assign readHit  = reqRead && hit;
  assign readMiss = reqRead && !hit;

  // Write-through, so every write reaches memory
  assign memRead  = readMiss;
  assign memWrite = reqWrite;
  assign memAddr  = reqAddr;
  assign memWdata = reqWdata;

  // Hits and writes answer at once, a miss one cycle later
  assign respValid = readHit || reqWrite || missPending;
  assign respData  = missPending ? memRdata : dataArray[reqIndex];

  // =====================================================================
  // Control state and counters
  // =====================================================================
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      validBits   <= '0;
      missPending <= 1'b0;
      hitCount    <= '0;
      missCount   <= '0;
    end else begin
      missPending <= readMiss;

      if (missPending) begin
        validBits[missIndex] <= 1'b1;   // Fill completes
      end

      // No allocate on write, a hit just drops the stale line
      if (reqWrite && hit) begin
        validBits[reqIndex] <= 1'b0;
      end

      if (readHit) hitCount <= hitCount + 1'b1;
      if (readMiss) missCount <= missCount + 1'b1;
    end
  end

  // Tag and data payload
  always_ff @(posedge clock) begin
    if (readMiss) begin
      missIndex <= reqIndex;
      missTag   <= reqTag;
    end
    if (missPending) begin
      tagArray[missIndex]  <= missTag;
      dataArray[missIndex] <= memRdata;
    end
  end

  // =====================================================================
  // Checks
  // =====================================================================
  assert property (@(posedge clock) disable iff (reset) !(reqRead && reqWrite));

  // The APB side holds off new work until the fill is done
  assert property (@(posedge clock) disable iff (reset)
    missPending |-> !(reqRead || reqWrite));

endmodule

//--- dataMemory.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module dataMemory (
  input  logic              clock,
  input  logic              memRead,
  input  logic              memWrite,
  input  cachePkg::memAddrT memAddr,
  input  cachePkg::wordT    memWdata,
  output cachePkg::wordT    memRdata
);
  import cachePkg::*;

  // =====================================================================
  // Word storage
  // =====================================================================
  wordT memArray [`MEM_WORDS];

  // Write lands on the request edge
  always_ff @(posedge clock) begin
    if (memWrite) begin
      memArray[memAddr] <= memWdata;
    end
  end

  // Registered read, data valid the cycle after memRead
  always_ff @(posedge clock) begin
    if (memRead) begin
      memRdata <= memArray[memAddr];
    end
  end

endmodule

//--- sim.f
+incdir+.
cachePkg.sv
dataMemory.sv
dataCache.sv
apbSlavePort.sv
cacheSubsystem.sv
tb_cacheSubsystem.sv

//--- tb_cacheSubsystem.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module tb_cacheSubsystem;
  import cachePkg::*;

  // Transfers per test are 2, 3, 12, 5, 9 and 216 for the random mix
  localparam int plannedTransfers = 247;
  localparam int cycleLimit       = 20 * plannedTransfers;
  localparam int randomOps        = 200;

  logic     clock;
  logic     reset;
  logic     psel;
  logic     penable;
  logic     pwrite;
  byteAddrT paddr;
  wordT     pwdata;
  wordT     prdata;
  logic     pready;
  logic     pslverr;

  // Reference model over the first 64 words
  wordT                    modelMem [64];
  logic [63:0]             written;
  tagT                     modelTag [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] modelValid;
  int                      expHits;
  int                      expMisses;

  logic [31:0] lfsr;
  int          cycleCount;
  int          errorCount;
  int          errorsAtStart;
  int          testsPassed;
  int          testsFailed;
  string       currentTest;

  cacheSubsystem u_dut (
    .clock   (clock),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, a transfer never completed", cycleCount);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ======================================================================
  // Helpers
  // ======================================================================
  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return value;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      errorCount++;
      $display("Fail %s (%s): expected %0h, actual %0h", currentTest, what, expected, actual);
    end
  endtask

  // Setup cycle, then access cycles until pready
  task automatic runTransfer(input logic write, input byteAddrT addr, input wordT data,
                             output wordT rdata, output logic err, output int waits);
    @(negedge clock);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(negedge clock);
    penable = 1'b1;
    waits   = 0;
    #1;   // Combinational response settles
    while (!pready) begin
      @(negedge clock);
      #1;
      waits++;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clock);   // Transfer ended on the rising edge
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apbWrite(input byteAddrT addr, input wordT data,
                          output logic err, output int waits);
    wordT unused;
    runTransfer(1'b1, addr, data, unused, err, waits);
  endtask

  task automatic apbRead(input byteAddrT addr, output wordT rdata,
                         output logic err, output int waits);
    runTransfer(1'b0, addr, '0, rdata, err, waits);
  endtask

  // Expected wait states of a read with the model line filled on a miss
  function automatic int predictRead(input logic [5:0] word);
    indexT idx;
    tagT   tag;
    idx = word[1:0];
    tag = tagT'(word >> 2);
    if (modelValid[idx] && modelTag[idx] == tag) begin
      expHits++;
      return 0;
    end
    expMisses++;
    modelValid[idx] = 1'b1;
    modelTag[idx]   = tag;
    return 1;
  endfunction

  function automatic void recordWrite(input logic [5:0] word, input wordT data);
    modelMem[word] = data;
    written[word]  = 1'b1;
    if (modelValid[word[1:0]] && modelTag[word[1:0]] == tagT'(word >> 2)) begin
      modelValid[word[1:0]] = 1'b0;   // No allocate so the stale line is dropped
    end
  endfunction

  task automatic checkedRead(input logic [5:0] word);
    wordT rdata;
    logic err;
    int   waits;
    int   expWaits;
    expWaits = predictRead(word);
    apbRead(byteAddrT'({word, 2'b00}), rdata, err, waits);
    checkValue($sformatf("data at word %0d", word), modelMem[word], rdata);
    checkValue($sformatf("wait states at word %0d", word), expWaits, waits);
    checkValue($sformatf("pslverr at word %0d", word), 0, err);
  endtask

  task automatic checkedWrite(input logic [5:0] word, input wordT data);
    logic err;
    int   waits;
    recordWrite(word, data);
    apbWrite(byteAddrT'({word, 2'b00}), data, err, waits);
    checkValue($sformatf("write wait states at word %0d", word), 0, waits);
    checkValue($sformatf("write pslverr at word %0d", word), 0, err);
  endtask

  task automatic readCounters(output int hits, output int misses);
    wordT rdata;
    logic err;
    int   waits;
    apbRead(`HIT_COUNT_ADDR, rdata, err, waits);
    hits = rdata;
    checkValue("hit counter", expHits, rdata);
    checkValue("hit counter response", 0, {err, waits[30:0]});
    apbRead(`MISS_COUNT_ADDR, rdata, err, waits);
    misses = rdata;
    checkValue("miss counter", expMisses, rdata);
    checkValue("miss counter response", 0, {err, waits[30:0]});
  endtask

  task automatic expectError(input logic write, input byteAddrT addr);
    wordT rdata;
    logic err;
    int   waits;
    runTransfer(write, addr, randBits(32), rdata, err, waits);
    checkValue($sformatf("pslverr at %0h", addr), 1, err);
    checkValue($sformatf("wait states at %0h", addr), 0, waits);
  endtask

  task automatic startTest(input string name);
    currentTest   = name;
    errorsAtStart = errorCount;
  endtask

  task automatic finishTest();
    if (errorCount == errorsAtStart) begin
      testsPassed++;
      $display("Test %s passed", currentTest);
    end else begin
      testsFailed++;
      $display("Test %s failed with %0d errors", currentTest, errorCount - errorsAtStart);
    end
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================
  initial begin
    int         hitsBefore;
    int         missesBefore;
    int         hitsAfter;
    int         missesAfter;
    logic [5:0] word;
    lfsr        = 32'hdc51_1e06;
    cycleCount  = 0;
    errorCount  = 0;
    testsPassed = 0;
    testsFailed = 0;
    written     = '0;
    modelValid  = '0;
    expHits     = 0;
    expMisses   = 0;
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    repeat (5) @(negedge clock);
    reset = 1'b0;

    startTest("writeThenRead");
    checkedWrite(6'd5, randBits(32));
    checkedRead(6'd5);   // Cold line takes one wait state
    finishTest();

    startTest("repeatedRead");
    hitsBefore   = expHits;
    missesBefore = expMisses;
    checkedRead(6'd5);
    readCounters(hitsAfter, missesAfter);
    checkValue("hit counter step", hitsBefore + 1, hitsAfter);
    checkValue("miss counter step", missesBefore, missesAfter);
    finishTest();

    // Words 8 and 24 share line 0
    startTest("conflictEviction");
    checkedWrite(6'd8, randBits(32));
    checkedWrite(6'd24, randBits(32));
    missesBefore = expMisses;
    for (int i = 0; i < 8; i++) begin
      checkedRead(i[0] ? 6'd24 : 6'd8);
    end
    readCounters(hitsAfter, missesAfter);
    checkValue("miss counter step", missesBefore + 8, missesAfter);
    finishTest();

    startTest("writeInvalidates");
    checkedRead(6'd5);
    checkedWrite(6'd5, randBits(32));
    checkedRead(6'd5);
    readCounters(hitsAfter, missesAfter);
    finishTest();

    // Words 0 and 4 alias the low bits of 0x1000 and 0x1010
    startTest("errorResponses");
    checkedWrite(6'd0, randBits(32));
    checkedWrite(6'd4, randBits(32));
    hitsBefore   = expHits;
    missesBefore = expMisses;
    expectError(1'b0, 13'h1008);
    expectError(1'b1, 13'h1010);
    expectError(1'b1, `HIT_COUNT_ADDR);
    readCounters(hitsAfter, missesAfter);
    checkValue("hit counter unchanged", hitsBefore, hitsAfter);
    checkValue("miss counter unchanged", missesBefore, missesAfter);
    checkedRead(6'd0);
    checkedRead(6'd4);
    finishTest();

    startTest("randomMix");
    for (int n = 0; n < randomOps; n++) begin
      word = randBits(6);
      if (randBits(1) || !written[word]) begin
        checkedWrite(word, randBits(32));
      end else begin
        checkedRead(word);
      end
      if (n % 25 == 24) readCounters(hitsAfter, missesAfter);
    end
    finishTest();

    $display("Tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
    if (testsFailed == 0 && errorCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
